// ==== source/caddr_mem_pkg.sv ====
package caddr_mem_pkg;

   localparam int mem_words = 4096;
   localparam int adr_bits = 12;
   localparam logic [adr_bits-1:0] vram_base = 12'd3072; // video region sits on top
   localparam int vram_bits = 10;
   localparam int main_limit = 3072; // main port stays below the video region
   localparam int scan_words = 256;

   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [adr_bits-1:0] adr;
      logic [31:0]         dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] dat;
   } pix_t;

   // order here is the round-robin order
   typedef enum logic [1:0] {
      m_scan,
      m_main,
      m_vram
   } master_t;

   typedef enum logic [1:0] {
      arb_idle,
      arb_grant,
      arb_done
   } arb_state_t;

   typedef enum logic [1:0] {
      scan_idle,
      scan_req,
      scan_wait
   } scan_state_t;

endpackage

// ==== source/mem_store.sv ====
`timescale 1ns/1ns

module mem_store (
   input  logic                   clk50,
   input  logic                   reset,
   input  caddr_mem_pkg::wb_req_t req,
   output caddr_mem_pkg::wb_rsp_t rsp
);

   logic [31:0] mem [caddr_mem_pkg::mem_words];
   logic [31:0] rd_dat;
   logic        ack;
   logic        take;

   // a held stb sees the ack first and is not served again
   assign take = req.cyc && req.stb && !ack;

   always_ff @(posedge clk50)
   begin
      if (reset)
      begin
         ack <= 1'b0;
      end
      else
      begin
         ack <= take;
      end
   end

   always_ff @(posedge clk50)
   begin
      if (take)
      begin
         if (req.we)
         begin
            mem[req.adr] <= req.dat;
         end
         else
         begin
            rd_dat <= mem[req.adr]; // one cycle read
         end
      end
   end

   assign rsp = '{ack: ack, dat: rd_dat};

   a_ack_after_stb: assert property (
      @(posedge clk50) disable iff (reset)
      rsp.ack |-> $past(req.cyc && req.stb)
   )
   else
      $error("store ack without a request in the previous cycle");

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter (
   input  logic                   clk50,
   input  logic                   reset,
   input  caddr_mem_pkg::wb_req_t scan_req,
   output caddr_mem_pkg::wb_rsp_t scan_rsp,
   input  caddr_mem_pkg::wb_req_t main_req,
   output caddr_mem_pkg::wb_rsp_t main_rsp,
   input  caddr_mem_pkg::wb_req_t vram_req,
   output caddr_mem_pkg::wb_rsp_t vram_rsp,
   output caddr_mem_pkg::wb_req_t store_req,
   input  caddr_mem_pkg::wb_rsp_t store_rsp
);

   caddr_mem_pkg::arb_state_t state;
   caddr_mem_pkg::master_t    last_grant; // also the current grant while busy
   caddr_mem_pkg::master_t    pick;
   caddr_mem_pkg::wb_req_t    sel;
   logic [2:0]                want;
   logic                      found;
   logic                      served;

   function automatic caddr_mem_pkg::master_t next_master(caddr_mem_pkg::master_t m);
      case (m)
         caddr_mem_pkg::m_scan: return caddr_mem_pkg::m_main;
         caddr_mem_pkg::m_main: return caddr_mem_pkg::m_vram;
         default:               return caddr_mem_pkg::m_scan;
      endcase
   endfunction

   // video offset into the video region of the store
   function automatic caddr_mem_pkg::wb_req_t to_video(caddr_mem_pkg::wb_req_t r);
      caddr_mem_pkg::wb_req_t m;
      m = r;
      m.adr = caddr_mem_pkg::vram_base
            + {{(caddr_mem_pkg::adr_bits - caddr_mem_pkg::vram_bits){1'b0}},
               r.adr[caddr_mem_pkg::vram_bits-1:0]};
      return m;
   endfunction

   assign want = {vram_req.cyc & vram_req.stb,
                  main_req.cyc & main_req.stb,
                  scan_req.cyc & scan_req.stb};

   // first requester after the last granted one
   always_comb
   begin
      caddr_mem_pkg::master_t cand;
      cand = last_grant;
      pick = last_grant;
      found = 1'b0;
      for (int i = 0; i < 3; i++)
      begin
         cand = next_master(cand);
         if (!found && want[cand])
         begin
            pick = cand;
            found = 1'b1;
         end
      end
   end

   always_ff @(posedge clk50)
   begin
      if (reset)
      begin
         state <= caddr_mem_pkg::arb_idle;
         last_grant <= caddr_mem_pkg::m_vram; // scanner goes first
      end
      else
      begin
         case (state)
            caddr_mem_pkg::arb_idle:
               if (found)
               begin
                  last_grant <= pick;
                  state <= caddr_mem_pkg::arb_grant;
               end
            caddr_mem_pkg::arb_grant:
               if (store_rsp.ack)
               begin
                  state <= caddr_mem_pkg::arb_done;
               end
            default:
               state <= caddr_mem_pkg::arb_idle;
         endcase
      end
   end

   always_comb
   begin
      case (last_grant)
         caddr_mem_pkg::m_scan: sel = to_video(scan_req);
         caddr_mem_pkg::m_main: sel = main_req;
         default:               sel = to_video(vram_req);
      endcase
      store_req = sel;
      store_req.cyc = sel.cyc && (state == caddr_mem_pkg::arb_grant);
      store_req.stb = sel.stb && (state == caddr_mem_pkg::arb_grant);
   end

   assign served = store_rsp.ack && (state == caddr_mem_pkg::arb_grant);

   assign scan_rsp = '{ack: served && (last_grant == caddr_mem_pkg::m_scan),
                       dat: store_rsp.dat};
   assign main_rsp = '{ack: served && (last_grant == caddr_mem_pkg::m_main),
                       dat: store_rsp.dat};
   assign vram_rsp = '{ack: served && (last_grant == caddr_mem_pkg::m_vram),
                       dat: store_rsp.dat};

   a_one_ack: assert property (
      @(posedge clk50) disable iff (reset)
      $onehot0({scan_rsp.ack, main_rsp.ack, vram_rsp.ack})
   )
   else
      $error("more than one master acked in the same cycle");

   // the granted master holds stb for the whole grant
   a_stb_in_grant: assert property (
      @(posedge clk50) disable iff (reset)
      store_req.stb == (state == caddr_mem_pkg::arb_grant)
   )
   else
      $error("store stb and arb_grant disagree");

endmodule

// ==== source/vram_scan.sv ====
`timescale 1ns/1ns

module vram_scan (
   input  logic                   clk50,
   input  logic                   reset,
   input  logic                   frame_start,
   output caddr_mem_pkg::wb_req_t scan_req,
   input  caddr_mem_pkg::wb_rsp_t scan_rsp,
   output caddr_mem_pkg::pix_t    pix,
   output logic                   scan_busy
);

   caddr_mem_pkg::scan_state_t        state;
   logic [caddr_mem_pkg::vram_bits-1:0] count; // current video offset
   logic                              pix_valid;
   logic [31:0]                       pix_dat;

   always_ff @(posedge clk50)
   begin
      if (reset)
      begin
         state <= caddr_mem_pkg::scan_idle;
         count <= '0;
         pix_valid <= 1'b0;
      end
      else
      begin
         pix_valid <= 1'b0;
         case (state)
            caddr_mem_pkg::scan_idle:
               if (frame_start)
               begin
                  count <= '0;
                  state <= caddr_mem_pkg::scan_req;
               end
            caddr_mem_pkg::scan_req:
               if (scan_rsp.ack)
               begin
                  pix_valid <= 1'b1; // pixel in the cycle after the ack
                  state <= caddr_mem_pkg::scan_wait;
               end
            default:
               if (count == caddr_mem_pkg::vram_bits'(caddr_mem_pkg::scan_words - 1))
               begin
                  state <= caddr_mem_pkg::scan_idle;
               end
               else
               begin
                  count <= count + 1'b1;
                  state <= caddr_mem_pkg::scan_req;
               end
         endcase
      end
   end

   always_ff @(posedge clk50)
   begin
      if (scan_rsp.ack)
      begin
         pix_dat <= scan_rsp.dat;
      end
   end

   always_comb
   begin
      scan_req.cyc = (state == caddr_mem_pkg::scan_req);
      scan_req.stb = (state == caddr_mem_pkg::scan_req);
      scan_req.we = 1'b0;
      scan_req.adr = {{(caddr_mem_pkg::adr_bits - caddr_mem_pkg::vram_bits){1'b0}}, count};
      scan_req.dat = '0;
   end

   assign pix = '{valid: pix_valid, dat: pix_dat};
   assign scan_busy = (state != caddr_mem_pkg::scan_idle);

   a_pix_in_frame: assert property (
      @(posedge clk50) disable iff (reset)
      pix.valid |-> scan_busy
   )
   else
      $error("pixel word outside a scan");

endmodule

// ==== source/caddr_mem_top.sv ====
`timescale 1ns/1ns

module caddr_mem_top (
   input  logic                   clk50,
   input  logic                   reset,
   input  logic                   frame_start,
   input  caddr_mem_pkg::wb_req_t main_req,
   output caddr_mem_pkg::wb_rsp_t main_rsp,
   input  caddr_mem_pkg::wb_req_t vram_req,
   output caddr_mem_pkg::wb_rsp_t vram_rsp,
   output caddr_mem_pkg::pix_t    pix,
   output logic                   scan_busy
);

   caddr_mem_pkg::wb_req_t scan_req;
   caddr_mem_pkg::wb_rsp_t scan_rsp;
   caddr_mem_pkg::wb_req_t store_req;
   caddr_mem_pkg::wb_rsp_t store_rsp;

   vram_scan scan0 (
      .clk50       (clk50),
      .reset       (reset),
      .frame_start (frame_start),
      .scan_req    (scan_req),
      .scan_rsp    (scan_rsp),
      .pix         (pix),
      .scan_busy   (scan_busy)
   );

   // three masters share the one store
   mem_arbiter arb0 (
      .clk50     (clk50),
      .reset     (reset),
      .scan_req  (scan_req),
      .scan_rsp  (scan_rsp),
      .main_req  (main_req),
      .main_rsp  (main_rsp),
      .vram_req  (vram_req),
      .vram_rsp  (vram_rsp),
      .store_req (store_req),
      .store_rsp (store_rsp)
   );

   mem_store store0 (
      .clk50 (clk50),
      .reset (reset),
      .req   (store_req),
      .rsp   (store_rsp)
   );

endmodule

// ==== dv/caddr_mem_checker.sv ====
`timescale 1ns/1ns

module caddr_mem_checker (
   input  logic                   clk50,
   input  logic                   reset,
   input  caddr_mem_pkg::wb_req_t main_req,
   input  caddr_mem_pkg::wb_rsp_t main_rsp,
   input  caddr_mem_pkg::wb_req_t vram_req,
   input  caddr_mem_pkg::wb_rsp_t vram_rsp,
   input  caddr_mem_pkg::pix_t    pix,
   input  logic                   scan_busy,
   output int                     data_errors,
   output int                     proto_errors,
   output int                     quiet_checks,
   output int                     frames
);

   logic [31:0]            model [caddr_mem_pkg::mem_words];
   logic                   known [caddr_mem_pkg::mem_words];
   caddr_mem_pkg::wb_req_t req [2]; // 0 is the main port, 1 the video port
   caddr_mem_pkg::wb_rsp_t rsp [2];
   logic                   pend [2];
   int                     rise_at [2];
   int                     last_act [2]; // last edge another master was active
   int                     others [2];   // other transfers acked while waiting
   int                     edge_n;
   int                     settle;
   int                     pix_n;
   int                     a;
   logic                   was_busy;

   function automatic int store_adr(int p, logic [11:0] adr);
      if (p == 0)
         return int'(adr);
      else
         return int'(caddr_mem_pkg::vram_base) + int'(adr[caddr_mem_pkg::vram_bits-1:0]);
   endfunction

   initial
   begin
      for (int i = 0; i < caddr_mem_pkg::mem_words; i++)
         known[i] = 1'b0;
      for (int p = 0; p < 2; p++)
      begin
         pend[p] = 1'b0;
         last_act[p] = -100;
      end
      data_errors = 0;
      proto_errors = 0;
      quiet_checks = 0;
      frames = 0;
      edge_n = 0;
      settle = 0;
      pix_n = 0;
      was_busy = 1'b0;
   end

   always @(posedge clk50)
   begin
      req[0] = main_req;
      req[1] = vram_req;
      rsp[0] = main_rsp;
      rsp[1] = vram_rsp;
      edge_n++;
      if ((reset || settle > 0) && (main_rsp.ack || vram_rsp.ack || pix.valid))
      begin
         proto_errors++;
         $display("[ERROR] %0t ns: ack or pixel word during or right after reset", $time);
      end
      if (reset)
      begin
         settle = 2;
         pend[0] = 1'b0;
         pend[1] = 1'b0;
         pix_n = 0;
         was_busy = 1'b0;
      end
      else
      begin
         if (settle > 0)
            settle--;
         for (int p = 0; p < 2; p++)
         begin
            if ((req[1-p].cyc && req[1-p].stb) || scan_busy)
               last_act[p] = edge_n;
            if (pend[p] && rsp[1-p].ack)
               others[p]++;
            if (pend[p] && pix.valid && edge_n > rise_at[p] + 1) // scanner ack was one edge earlier
               others[p]++;
            if (rsp[p].ack)
            begin
               if (!pend[p])
               begin
                  proto_errors++;
                  $display("[ERROR] %0t ns: port %0d acked with no request", $time, p);
               end
               else
               begin
                  a = store_adr(p, req[p].adr);
                  if (others[p] > 2)
                  begin
                     proto_errors++;
                     $display("[ERROR] %0t ns: port %0d waited for %0d transfers",
                              $time, p, others[p]);
                  end
                  if (last_act[p] < rise_at[p] - 1)
                  begin
                     quiet_checks++;
                     if (edge_n - rise_at[p] != 2)
                     begin
                        proto_errors++;
                        $display("[ERROR] %0t ns: port %0d acked after %0d edges, expected 2",
                                 $time, p, edge_n - rise_at[p]);
                     end
                  end
                  if (req[p].we)
                  begin
                     model[a] = req[p].dat;
                     known[a] = 1'b1;
                  end
                  else if (known[a] && rsp[p].dat !== model[a])
                  begin
                     data_errors++;
                     $display("[ERROR] %0t ns: port %0d read word %0d as %h, expected %h",
                              $time, p, a, rsp[p].dat, model[a]);
                  end
               end
               pend[p] = 1'b0;
            end
            else if (req[p].cyc && req[p].stb && !pend[p])
            begin
               pend[p] = 1'b1;
               rise_at[p] = edge_n;
               others[p] = 0;
            end
         end
         if (scan_busy && !was_busy)
            pix_n = 0;
         if (pix.valid)
         begin
            a = int'(caddr_mem_pkg::vram_base) + pix_n;
            if (pix_n >= caddr_mem_pkg::scan_words || (known[a] && pix.dat !== model[a]))
            begin
               data_errors++;
               $display("[ERROR] %0t ns: pixel word %0d is %h, expected %h",
                        $time, pix_n, pix.dat, model[a]);
            end
            pix_n++;
         end
         if (was_busy && !scan_busy)
         begin
            frames++;
            if (pix_n != caddr_mem_pkg::scan_words)
            begin
               proto_errors++;
               $display("[ERROR] %0t ns: frame gave %0d pixel words", $time, pix_n);
            end
         end
         was_busy = scan_busy;
      end
   end

endmodule

// ==== dv/caddr_mem_tb.sv ====
`timescale 1ns/1ns

module caddr_mem_tb;

   logic                   clk50;
   logic                   reset;
   logic                   frame_start;
   caddr_mem_pkg::wb_req_t main_req;
   caddr_mem_pkg::wb_rsp_t main_rsp;
   caddr_mem_pkg::wb_req_t vram_req;
   caddr_mem_pkg::wb_rsp_t vram_rsp;
   caddr_mem_pkg::pix_t    pix;
   logic                   scan_busy;
   logic [31:0]            lfsr;
   logic [31:0]            word;
   logic [11:0]            adr;
   int                     data_errors;
   int                     proto_errors;
   int                     quiet_checks;
   int                     frames;

   caddr_mem_top dut0 (
      .clk50       (clk50),
      .reset       (reset),
      .frame_start (frame_start),
      .main_req    (main_req),
      .main_rsp    (main_rsp),
      .vram_req    (vram_req),
      .vram_rsp    (vram_rsp),
      .pix         (pix),
      .scan_busy   (scan_busy)
   );

   caddr_mem_checker chk0 (
      .clk50        (clk50),
      .reset        (reset),
      .main_req     (main_req),
      .main_rsp     (main_rsp),
      .vram_req     (vram_req),
      .vram_rsp     (vram_rsp),
      .pix          (pix),
      .scan_busy    (scan_busy),
      .data_errors  (data_errors),
      .proto_errors (proto_errors),
      .quiet_checks (quiet_checks),
      .frames       (frames)
   );

   initial
      clk50 = 1'b0;
   always #4 clk50 = ~clk50;

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   // port 0 is the main port, 1 the video port
   task automatic transfer(input int port, input logic we, input logic [11:0] a,
                           input logic [31:0] d);
      caddr_mem_pkg::wb_req_t r;
      int                     waited;
      logic                   acked;
      r = '{cyc: 1'b1, stb: 1'b1, we: we, adr: a, dat: d};
      waited = 0;
      acked = 1'b0;
      @(posedge clk50);
      if (port == 0)
         main_req <= r;
      else
         vram_req <= r;
      while (!acked && waited < 100)
      begin
         @(posedge clk50);
         acked = (port == 0) ? main_rsp.ack : vram_rsp.ack;
         waited++;
      end
      if (!acked)
      begin
         $display("timeout: no ack on port %0d within 100 cycles", port);
         $display("test failed");
         $finish;
      end
      r.cyc = 1'b0;
      r.stb = 1'b0;
      if (port == 0)
         main_req <= r;
      else
         vram_req <= r;
   endtask

   task automatic run_frame();
      int   waited;
      logic busy;
      @(posedge clk50);
      frame_start <= 1'b1;
      @(posedge clk50);
      frame_start <= 1'b0;
      @(posedge clk50); // busy is up one edge after the strobe
      waited = 0;
      busy = 1'b1;
      while (busy && waited < 10000)
      begin
         @(posedge clk50);
         frame_start <= (waited == 20); // strobe while busy is ignored
         busy = scan_busy;
         waited++;
      end
      if (busy)
      begin
         $display("timeout: scan_busy still high after 10000 cycles");
         $display("test failed");
         $finish;
      end
   endtask

   task automatic port_traffic(input int port);
      logic        we;
      logic [11:0] a;
      for (int n = 0; n < 300; n++)
      begin
         we = take_bits(1);
         if (port == 0)
            a = 12'(take_bits(6)); // small window so reads hit writes
         else
            a = take_bits(1) ? 12'(take_bits(10)) : 12'(take_bits(8));
         transfer(port, we, a, take_bits(32));
         repeat (take_bits(3)) @(posedge clk50);
      end
   endtask

   initial
   begin
      lfsr = 32'h3e26;
      reset = 1'b1;
      frame_start = 1'b0;
      main_req = '0;
      vram_req = '0;
      repeat (16) @(posedge clk50);
      reset <= 1'b0;
      repeat (4) @(posedge clk50);
      word = take_bits(32);
      adr = 12'(take_bits(12) % caddr_mem_pkg::main_limit);
      transfer(0, 1'b1, adr, word);
      transfer(0, 1'b0, adr, '0);
      adr = 12'(take_bits(10));
      transfer(1, 1'b1, adr, take_bits(32));
      transfer(0, 1'b0, caddr_mem_pkg::vram_base + adr, '0);
      transfer(1, 1'b0, adr, '0);
      for (int i = 0; i < caddr_mem_pkg::scan_words; i++)
         transfer(1, 1'b1, 12'(i), take_bits(32));
      run_frame();
      fork
         port_traffic(0);
         port_traffic(1);
         repeat (3)
         begin
            repeat (take_bits(6)) @(posedge clk50);
            run_frame();
         end
      join
      repeat (10) @(posedge clk50);
      $display("data errors %0d, protocol errors %0d, uncontended checks %0d, frames %0d",
               data_errors, proto_errors, quiet_checks, frames);
      if (data_errors == 0 && proto_errors == 0 && quiet_checks > 0 && frames == 4)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// ==== caddr_mem.f ====
source/caddr_mem_pkg.sv
source/mem_store.sv
source/mem_arbiter.sv
source/vram_scan.sv
source/caddr_mem_top.sv
dv/caddr_mem_checker.sv
dv/caddr_mem_tb.sv
